// File: all.f
+incdir+common
common/clint_pkg.sv
clint/clint_regs.sv
clint/clint_axi_slave.sv
hw/clint_top.sv
bench/clint_checker.sv
bench/tb_clint.sv

// File: bench/tb_clint.sv
`timescale 1ns/1ps
`include "clint_defs.svh"

module tb_clint;
    import clint_pkg::*;

    localparam int NUM_TESTS    = 25;
    localparam int RESET_CYCLES = 8;

    // One bus request and its expected response
    typedef struct packed {
        logic [8*16-1:0] name;
        logic            is_write;
        logic [31:0]     addr;
        logic [31:0]     data;
        logic [3:0]      strb;
        logic [7:0]      len;
        logic [3:0]      id;
        logic [7:0]      gap;       // Idle cycles before the request
        logic            live;      // Expected data from the timer model
        logic [31:0]     exp_data;
        axi_resp_t       exp_resp;
    } entry_t;

    logic                       clock;
    logic                       reset;
    logic [`CLINT_ADDR_W-1:0]   araddr;
    logic                       arvalid;
    logic                       arready;
    logic [`CLINT_ID_W-1:0]     arid;
    logic [7:0]                 arlen;
    logic [2:0]                 arsize;
    logic [1:0]                 arburst;
    logic [`CLINT_DATA_W-1:0]   rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rlast;
    logic [`CLINT_ID_W-1:0]     rid;
    logic                       rready;
    logic [`CLINT_ADDR_W-1:0]   awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [`CLINT_ID_W-1:0]     awid;
    logic [7:0]                 awlen;
    logic [2:0]                 awsize;
    logic [1:0]                 awburst;
    logic [`CLINT_DATA_W-1:0]   wdata;
    logic [`CLINT_DATA_W/8-1:0] wstrb;
    logic                       wvalid;
    logic                       wready;
    logic                       wlast;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic [`CLINT_ID_W-1:0]     bid;
    logic                       bready;
    logic                       timer_irq;
    logic                       soft_irq;

    // Current entry, seen by the checker
    logic [8*16-1:0]            test_name;
    logic [`CLINT_DATA_W-1:0]   exp_data;
    axi_resp_t                  exp_resp;
    logic                       exp_live;

    entry_t tests [NUM_TESTS];
    int     n_loaded = 0;
    int     seed = 32'h3b49ddc8;
    int     failures;

    clint_top DUT (.*);

    clint_checker u_checker (.*);

    // ------------------------------------------------------------
    // Clock and watchdog
    // ------------------------------------------------------------
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * 40) @(posedge clock);
        $display("Timeout: the test table did not finish within %0d cycles",
                 RESET_CYCLES + NUM_TESTS * 40);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic add_entry(input logic [8*16-1:0] name, input logic wr,
                             input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [7:0] len,
                             input logic [3:0] id, input logic [7:0] gap,
                             input logic live, input logic [31:0] exp,
                             input axi_resp_t resp);
        tests[n_loaded] = {name, wr, addr, data, strb, len, id, gap, live, exp, resp};
        n_loaded++;
    endtask

    // Expected values follow the register map and timer rules
    task automatic load_tests();
        // Timer counts from reset
        add_entry("rd_time_lo", 0, `CLINT_MTIME_LO, 0, 4'hF, 0, 4'h1, 3, 1, 0, OKAY);
        add_entry("rd_time_hi", 0, `CLINT_MTIME_HI, 0, 4'hF, 0, 4'h2, 0, 1, 0, OKAY);
        // Bytes 0 and 2 over the all-ones reset value
        add_entry("wr_cmp_bytes", 1, `CLINT_CMP_LO, 32'h1234_5678, 4'b0101, 0, 4'h3, 0, 0, 0, OKAY);
        add_entry("rd_cmp_lo", 0, `CLINT_CMP_LO, 0, 4'hF, 0, 4'h4, 0, 0, 32'hFF34_FF78, OKAY);
        add_entry("rd_cmp_hi", 0, `CLINT_CMP_HI, 0, 4'hF, 0, 4'h5, 0, 0, 32'hFFFF_FFFF, OKAY);
        // Timer write, then carry into the high word
        add_entry("wr_time_lo", 1, `CLINT_MTIME_LO, 32'h0000_1000, 4'hF, 0, 4'h6, 0, 0, 0, OKAY);
        add_entry("rd_time_after", 0, `CLINT_MTIME_LO, 0, 4'hF, 0, 4'h7, 2, 1, 0, OKAY);
        add_entry("wr_near_wrap", 1, `CLINT_MTIME_LO, 32'hFFFF_FFF0, 4'hF, 0, 4'h8, 0, 0, 0, OKAY);
        add_entry("rd_carry_hi", 0, `CLINT_MTIME_HI, 0, 4'hF, 0, 4'h9, 24, 0, 1, OKAY);
        // Compare a few counts above the timer
        add_entry("wr_time_hi0", 1, `CLINT_MTIME_HI, 0, 4'hF, 0, 4'hA, 0, 0, 0, OKAY);
        add_entry("wr_cmp_hi0", 1, `CLINT_CMP_HI, 0, 4'hF, 0, 4'hB, 0, 0, 0, OKAY);
        add_entry("wr_time_100", 1, `CLINT_MTIME_LO, 32'h100, 4'hF, 0, 4'hC, 0, 0, 0, OKAY);
        add_entry("wr_cmp_120", 1, `CLINT_CMP_LO, 32'h120, 4'hF, 0, 4'hD, 0, 0, 0, OKAY);
        add_entry("rd_time_irq", 0, `CLINT_MTIME_LO, 0, 4'hF, 0, 4'hE, 48, 1, 0, OKAY);
        add_entry("wr_cmp_hi1", 1, `CLINT_CMP_HI, 1, 4'hF, 0, 4'hF, 0, 0, 0, OKAY);
        add_entry("rd_cmp_hi1", 0, `CLINT_CMP_HI, 0, 4'hF, 0, 4'h0, 2, 0, 1, OKAY);
        // Software interrupt, only bit 0 sticks
        add_entry("wr_msip_set", 1, `CLINT_MSIP, 32'hFFFF_FFFF, 4'hF, 0, 4'h1, 0, 0, 0, OKAY);
        add_entry("rd_msip_1", 0, `CLINT_MSIP, 0, 4'hF, 0, 4'h2, 0, 0, 1, OKAY);
        add_entry("wr_msip_clr", 1, `CLINT_MSIP, 0, 4'hF, 0, 4'h3, 0, 0, 0, OKAY);
        add_entry("rd_msip_0", 0, `CLINT_MSIP, 0, 4'hF, 0, 4'h4, 0, 0, 0, OKAY);
        // Rejected requests
        add_entry("rd_unmapped", 0, 32'h0200_0014, 0, 4'hF, 0, 4'h9, 0, 0, 0, SLVERR);
        add_entry("wr_unmapped", 1, 32'h0200_0100, 32'h55, 4'hF, 0, 4'h5, 0, 0, 0, SLVERR);
        add_entry("rd_burst", 0, `CLINT_MTIME_LO, 0, 4'hF, 3, 4'hA, 0, 0, 0, SLVERR);
        add_entry("wr_burst", 1, `CLINT_MSIP, 1, 4'hF, 1, 4'h6, 0, 0, 0, SLVERR);
        add_entry("rd_msip_rej", 0, `CLINT_MSIP, 0, 4'hF, 0, 4'h7, 0, 0, 0, OKAY);
    endtask

    // ------------------------------------------------------------
    // One request, then its response after a random stall
    // ------------------------------------------------------------
    task automatic run_entry(input entry_t e);
        int stall;
        stall     = $unsigned($random(seed)) % 8;
        test_name = e.name;
        exp_data  = e.exp_data;
        exp_resp  = e.exp_resp;
        exp_live  = e.live;
        if (e.is_write) begin
            awaddr  = e.addr;
            awid    = e.id;
            awlen   = e.len;
            wdata   = e.data;
            wstrb   = e.strb;
            awvalid = 1'b1;
            wvalid  = 1'b1;
            do @(negedge clock); while (!bvalid);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            repeat (stall) @(negedge clock);
            bready = 1'b1;
            do @(negedge clock); while (bvalid);
            bready = 1'b0;
        end else begin
            araddr  = e.addr;
            arid    = e.id;
            arlen   = e.len;
            arvalid = 1'b1;
            do @(negedge clock); while (!rvalid);
            arvalid = 1'b0;
            repeat (stall) @(negedge clock);
            rready = 1'b1;
            do @(negedge clock); while (rvalid);
            rready = 1'b0;
        end
    endtask

    initial begin
        reset     = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        arid      = '0;
        arlen     = '0;
        arsize    = 3'd2;
        arburst   = 2'b01;
        rready    = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        awid      = '0;
        awlen     = '0;
        awsize    = 3'd2;
        awburst   = 2'b01;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        wlast     = 1'b1;
        bready    = 1'b0;
        test_name = "reset";
        exp_data  = '0;
        exp_resp  = OKAY;
        exp_live  = 1'b0;
        load_tests();

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            repeat (tests[i].gap) @(negedge clock);
            run_entry(tests[i]);
        end

        repeat (4) @(negedge clock);
        u_checker.summarize(failures);
        if (failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: bench/clint_checker.sv
`timescale 1ns/1ps
`include "clint_defs.svh"

module clint_checker (
    input logic                       clock,
    input logic                       reset,
    // AR and R channels
    input logic [`CLINT_ADDR_W-1:0]   araddr,
    input logic                       arvalid,
    input logic                       arready,
    input logic [`CLINT_ID_W-1:0]     arid,
    input logic [`CLINT_DATA_W-1:0]   rdata,
    input logic [1:0]                 rresp,
    input logic                       rvalid,
    input logic                       rlast,
    input logic [`CLINT_ID_W-1:0]     rid,
    input logic                       rready,
    // AW, W and B channels
    input logic [`CLINT_ADDR_W-1:0]   awaddr,
    input logic                       awvalid,
    input logic                       awready,
    input logic [`CLINT_ID_W-1:0]     awid,
    input logic [`CLINT_DATA_W-1:0]   wdata,
    input logic [`CLINT_DATA_W/8-1:0] wstrb,
    input logic                       wvalid,
    input logic                       wready,
    input logic [1:0]                 bresp,
    input logic                       bvalid,
    input logic [`CLINT_ID_W-1:0]     bid,
    input logic                       bready,
    input logic                       timer_irq,
    input logic                       soft_irq,
    // Current table entry
    input logic [8*16-1:0]            test_name,
    input logic [`CLINT_DATA_W-1:0]   exp_data,
    input clint_pkg::axi_resp_t       exp_resp,
    input logic                       exp_live
);
    import clint_pkg::*;

    int tests_run = 0;
    int tests_failed = 0;
    int other_errors = 0;

    // Reference model of the register block
    logic [63:0] m_time;
    logic [63:0] m_cmp;
    logic        m_msip;
    logic        m_irq;
    logic        irq_next;

    // Accepted write, commits on the following edge
    logic        pend;
    logic [31:0] pend_addr;
    logic [31:0] pend_data;
    logic [3:0]  pend_strb;

    // Expected response fields, captured at the address handshake
    logic [31:0] r_exp;
    logic [3:0]  r_id;
    logic [3:0]  b_id;
    logic        bad;

    // Response values seen on a stalled edge
    logic        r_hold;
    logic        b_hold;
    logic [31:0] h_rdata;
    logic [1:0]  h_rresp;
    logic [3:0]  h_rid;
    logic [1:0]  h_bresp;
    logic [3:0]  h_bid;

    // Interrupt activity seen on the outputs
    logic timer_rose = 1'b0;
    logic timer_fell = 1'b0;
    logic soft_rose = 1'b0;
    logic soft_fell = 1'b0;

    // Per-byte write under strobe
    function automatic logic [31:0] apply_bytes(
        input logic [31:0] cur,
        input logic [31:0] upd,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = upd[8*b +: 8];
        end
        return res;
    endfunction

    task automatic mismatch(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("[FAIL] %0s %0s expected %h actual %h", test_name, what, expected, actual);
        bad = 1'b1;
    endtask

    task automatic note_error(input string msg);
        $display("ERROR: %0s during %0s", msg, test_name);
        other_errors++;
    endtask

    task automatic close_test();
        tests_run++;
        if (bad) tests_failed++;
        else $display("[PASS] %0s", test_name);
    endtask

    // ------------------------------------------------------------
    // Edge-by-edge model and comparison
    // ------------------------------------------------------------
    always @(posedge clock) begin
        if (reset) begin
            m_time = '0;
            m_cmp  = `CLINT_CMP_RESET;
            m_msip = 1'b0;
            m_irq  = 1'b0;
            pend   = 1'b0;
            r_hold = 1'b0;
            b_hold = 1'b0;
        end else begin
            // Interrupt outputs
            if (timer_irq !== m_irq) begin
                $display("[FAIL] %0s timer_irq expected %b actual %b",
                         test_name, m_irq, timer_irq);
                other_errors++;
            end
            if (soft_irq !== m_msip) begin
                $display("[FAIL] %0s soft_irq expected %b actual %b",
                         test_name, m_msip, soft_irq);
                other_errors++;
            end
            if (timer_irq) timer_rose = 1'b1;
            if (timer_rose && !timer_irq) timer_fell = 1'b1;
            if (soft_irq) soft_rose = 1'b1;
            if (soft_rose && !soft_irq) soft_fell = 1'b1;

            // Stalled responses hold still
            if (r_hold && (!rvalid || rdata !== h_rdata || rresp !== h_rresp || rid !== h_rid))
                note_error("read response changed while rready was low");
            if (b_hold && (!bvalid || bresp !== h_bresp || bid !== h_bid))
                note_error("write response changed while bready was low");
            if (rvalid && arready) note_error("arready high with a read response pending");
            if (bvalid && (awready || wready))
                note_error("write channel ready with a write response pending");

            // Read side, data is the value just before the AR edge
            if (arvalid && arready) begin
                if (!exp_live) r_exp = exp_data;
                else if (araddr == `CLINT_MTIME_HI) r_exp = m_time[63:32];
                else r_exp = m_time[31:0];
                r_id = arid;
            end
            if (rvalid && rready) begin
                bad = 1'b0;
                if (rdata !== r_exp) mismatch("rdata", r_exp, rdata);
                if (rresp !== exp_resp) mismatch("rresp", exp_resp, rresp);
                if (rid !== r_id) mismatch("rid", r_id, rid);
                if (rlast !== 1'b1) mismatch("rlast", 1, rlast);
                close_test();
            end

            // Write side
            if (awvalid && awready) b_id = awid;
            if (bvalid && bready) begin
                bad = 1'b0;
                if (bresp !== exp_resp) mismatch("bresp", exp_resp, bresp);
                if (bid !== b_id) mismatch("bid", b_id, bid);
                close_test();
            end

            r_hold  = rvalid && !rready;
            h_rdata = rdata;
            h_rresp = rresp;
            h_rid   = rid;
            b_hold  = bvalid && !bready;
            h_bresp = bresp;
            h_bid   = bid;

            // Model update, compare uses the old timer value
            irq_next = (m_time >= m_cmp);
            if (pend && pend_addr == `CLINT_MTIME_LO)
                m_time[31:0] = apply_bytes(m_time[31:0], pend_data, pend_strb);
            else if (pend && pend_addr == `CLINT_MTIME_HI)
                m_time[63:32] = apply_bytes(m_time[63:32], pend_data, pend_strb);
            else
                m_time = m_time + 64'd1;
            if (pend && pend_addr == `CLINT_CMP_LO)
                m_cmp[31:0] = apply_bytes(m_cmp[31:0], pend_data, pend_strb);
            if (pend && pend_addr == `CLINT_CMP_HI)
                m_cmp[63:32] = apply_bytes(m_cmp[63:32], pend_data, pend_strb);
            if (pend && pend_addr == `CLINT_MSIP && pend_strb[0])
                m_msip = pend_data[0];
            m_irq = irq_next;

            // Commit one edge after the AW/W handshake, none when rejected
            pend      = awvalid && awready && wvalid && wready && (exp_resp == OKAY);
            pend_addr = awaddr;
            pend_data = wdata;
            pend_strb = wstrb;
        end
    end

    // Closing counts
    task automatic summarize(output int failures);
        if (!timer_rose || !timer_fell) note_error("timer_irq did not both rise and fall");
        if (!soft_rose || !soft_fell) note_error("soft_irq did not both rise and fall");
        $display("Tests run %0d, passed %0d, failed %0d, other errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, other_errors);
        failures = tests_failed + other_errors;
    endtask

endmodule

// File: hw/clint_top.sv
`timescale 1ns/1ps
`include "clint_defs.svh"

module clint_top (
    input  logic                       clock,
    input  logic                       reset,
    // AR channel
    input  logic [`CLINT_ADDR_W-1:0]   araddr,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [`CLINT_ID_W-1:0]     arid,
    input  logic [7:0]                 arlen,
    input  logic [2:0]                 arsize,
    input  logic [1:0]                 arburst,
    // R channel
    output logic [`CLINT_DATA_W-1:0]   rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    output logic                       rlast,
    output logic [`CLINT_ID_W-1:0]     rid,
    input  logic                       rready,
    // AW channel
    input  logic [`CLINT_ADDR_W-1:0]   awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`CLINT_ID_W-1:0]     awid,
    input  logic [7:0]                 awlen,
    input  logic [2:0]                 awsize,
    input  logic [1:0]                 awburst,
    // W channel
    input  logic [`CLINT_DATA_W-1:0]   wdata,
    input  logic [`CLINT_DATA_W/8-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic                       wlast,
    // B channel
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    output logic [`CLINT_ID_W-1:0]     bid,
    input  logic                       bready,
    // Interrupts
    output logic                       timer_irq,
    output logic                       soft_irq
);
    import clint_pkg::*;

    // ------------------------------------------------------------
    // Decoded register interface
    // ------------------------------------------------------------
    reg_sel_t                   rd_sel;
    logic [`CLINT_DATA_W-1:0]   rd_data;
    logic                       wr_en;
    reg_sel_t                   wr_sel;
    logic [`CLINT_DATA_W-1:0]   wr_data;
    logic [`CLINT_DATA_W/8-1:0] wr_strb;

    // Port names match the bus and the register interface
    clint_axi_slave u_axi_slave (.*);

    // Timer, compare and msip
    clint_regs u_regs (.*);

endmodule

// File: clint/clint_axi_slave.sv
`timescale 1ns/1ps
`include "clint_defs.svh"

module clint_axi_slave (
    input  logic                       clock,
    input  logic                       reset,
    // AR channel
    input  logic [`CLINT_ADDR_W-1:0]   araddr,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [`CLINT_ID_W-1:0]     arid,
    input  logic [7:0]                 arlen,
    input  logic [2:0]                 arsize,
    input  logic [1:0]                 arburst,
    // R channel
    output logic [`CLINT_DATA_W-1:0]   rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    output logic                       rlast,
    output logic [`CLINT_ID_W-1:0]     rid,
    input  logic                       rready,
    // AW channel
    input  logic [`CLINT_ADDR_W-1:0]   awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`CLINT_ID_W-1:0]     awid,
    input  logic [7:0]                 awlen,
    input  logic [2:0]                 awsize,
    input  logic [1:0]                 awburst,
    // W channel
    input  logic [`CLINT_DATA_W-1:0]   wdata,
    input  logic [`CLINT_DATA_W/8-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic                       wlast,
    // B channel
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    output logic [`CLINT_ID_W-1:0]     bid,
    input  logic                       bready,
    // Register block side
    output clint_pkg::reg_sel_t        rd_sel,
    input  logic [`CLINT_DATA_W-1:0]   rd_data,
    output logic                       wr_en,
    output clint_pkg::reg_sel_t        wr_sel,
    output logic [`CLINT_DATA_W-1:0]   wr_data,
    output logic [`CLINT_DATA_W/8-1:0] wr_strb
);
    import clint_pkg::*;

    bus_state_t rd_state;
    bus_state_t wr_state;
    reg_sel_t   ar_sel;
    reg_sel_t   aw_sel;
    logic       ar_reject;
    logic       aw_reject;
    logic       wr_accept;

    // Address decode, exact word match only
    function automatic reg_sel_t decode(input logic [`CLINT_ADDR_W-1:0] addr);
        case (addr)
            `CLINT_MTIME_LO: decode = MTIME_LO;
            `CLINT_MTIME_HI: decode = MTIME_HI;
            `CLINT_CMP_LO:   decode = CMP_LO;
            `CLINT_CMP_HI:   decode = CMP_HI;
            `CLINT_MSIP:     decode = MSIP;
            default:         decode = NONE;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------
    assign ar_sel    = decode(araddr);
    assign ar_reject = (ar_sel == NONE) || (arlen != 8'd0);
    // Register block looks up the live address
    assign rd_sel    = ar_sel;

    assign arready = (rd_state == IDLE);
    assign rvalid  = (rd_state != IDLE);
    // Single beat, so every beat is the last
    assign rlast   = rvalid;
    assign rresp   = (rd_state == REJECT) ? SLVERR : OKAY;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_state <= IDLE;
        end else begin
            case (rd_state)
                IDLE: begin
                    if (arvalid) begin
                        if (ar_reject) rd_state <= REJECT;
                        else           rd_state <= RESP;
                    end
                end
                RESP, REJECT: begin
                    if (rready) rd_state <= IDLE;
                end
                default: rd_state <= IDLE;
            endcase
        end
    end

    // Capture data and ID at the AR handshake
    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rdata <= ar_reject ? '0 : rd_data;
            rid   <= arid;
        end
    end

    // ------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------
    assign aw_sel    = decode(awaddr);
    assign aw_reject = (aw_sel == NONE) || (awlen != 8'd0);

    // AW and W taken together on one edge
    assign wr_accept = (wr_state == IDLE) && awvalid && wvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign bvalid = (wr_state != IDLE);
    assign bresp  = (wr_state == REJECT) ? SLVERR : OKAY;

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_state <= IDLE;
            wr_en    <= 1'b0;
        end else begin
            // Commit pulse, none for a rejected write
            wr_en <= wr_accept && !aw_reject;
            case (wr_state)
                IDLE: begin
                    if (wr_accept) begin
                        if (aw_reject) wr_state <= REJECT;
                        else           wr_state <= RESP;
                    end
                end
                RESP, REJECT: begin
                    if (bready) wr_state <= IDLE;
                end
                default: wr_state <= IDLE;
            endcase
        end
    end

    // Write payload and ID
    always_ff @(posedge clock) begin
        if (wr_accept) begin
            wr_sel  <= aw_sel;
            wr_data <= wdata;
            wr_strb <= wstrb;
            bid     <= awid;
        end
    end

endmodule

// File: clint/clint_regs.sv
`timescale 1ns/1ps
`include "clint_defs.svh"

module clint_regs (
    input  logic                       clock,
    input  logic                       reset,
    // Read port, data returned in the same cycle
    input  clint_pkg::reg_sel_t        rd_sel,
    output logic [`CLINT_DATA_W-1:0]   rd_data,
    // Write port, one-cycle pulse from the bus slave
    input  logic                       wr_en,
    input  clint_pkg::reg_sel_t        wr_sel,
    input  logic [`CLINT_DATA_W-1:0]   wr_data,
    input  logic [`CLINT_DATA_W/8-1:0] wr_strb,
    // Interrupts to the core
    output logic                       timer_irq,
    output logic                       soft_irq
);
    import clint_pkg::*;

    // Timer as two words, carry goes low to high
    logic [`CLINT_DATA_W-1:0]   mtime_lo;
    logic [`CLINT_DATA_W-1:0]   mtime_hi;
    logic [2*`CLINT_DATA_W-1:0] mtimecmp;
    logic                       msip;

    logic                       mtime_wr;
    logic                       lo_carry;

    // Byte merge under strobe
    function automatic logic [`CLINT_DATA_W-1:0] merge(
        input logic [`CLINT_DATA_W-1:0]   old_word,
        input logic [`CLINT_DATA_W-1:0]   new_word,
        input logic [`CLINT_DATA_W/8-1:0] strb
    );
        logic [`CLINT_DATA_W-1:0] result;
        result = old_word;
        for (int i = 0; i < `CLINT_DATA_W/8; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    // Any mtime write freezes the count for that edge
    assign mtime_wr = wr_en && (wr_sel == MTIME_LO || wr_sel == MTIME_HI);
    assign lo_carry = (mtime_lo == '1);

    // ------------------------------------------------------------
    // mtime counter
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            mtime_lo <= '0;
        end else if (wr_en && wr_sel == MTIME_LO) begin
            mtime_lo <= merge(mtime_lo, wr_data, wr_strb);
        end else if (!mtime_wr) begin
            // Wraps to zero on carry
            mtime_lo <= mtime_lo + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mtime_hi <= '0;
        end else if (wr_en && wr_sel == MTIME_HI) begin
            mtime_hi <= merge(mtime_hi, wr_data, wr_strb);
        end else if (!mtime_wr && lo_carry) begin
            mtime_hi <= mtime_hi + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Compare register and msip
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            mtimecmp <= `CLINT_CMP_RESET;
            msip     <= 1'b0;
        end else if (wr_en) begin
            case (wr_sel)
                CMP_LO: mtimecmp[`CLINT_DATA_W-1:0] <=
                    merge(mtimecmp[`CLINT_DATA_W-1:0], wr_data, wr_strb);
                CMP_HI: mtimecmp[2*`CLINT_DATA_W-1:`CLINT_DATA_W] <=
                    merge(mtimecmp[2*`CLINT_DATA_W-1:`CLINT_DATA_W], wr_data, wr_strb);
                // Only bit 0 is kept
                MSIP: if (wr_strb[0]) msip <= wr_data[0];
                default: ;
            endcase
        end
    end

    // Registered compare, one edge behind the counter
    always_ff @(posedge clock) begin
        if (reset) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= ({mtime_hi, mtime_lo} >= mtimecmp);
        end
    end

    assign soft_irq = msip;

    // Read mux
    always_comb begin
        case (rd_sel)
            MTIME_LO: rd_data = mtime_lo;
            MTIME_HI: rd_data = mtime_hi;
            CMP_LO:   rd_data = mtimecmp[`CLINT_DATA_W-1:0];
            CMP_HI:   rd_data = mtimecmp[2*`CLINT_DATA_W-1:`CLINT_DATA_W];
            MSIP:     rd_data = {{(`CLINT_DATA_W-1){1'b0}}, msip};
            default:  rd_data = '0;
        endcase
    end

endmodule

// File: common/clint_pkg.sv
// Shared types for the CLINT bus slave and register block
package clint_pkg;

    // ------------------------------------------------------------
    // Bus channel state machines
    // ------------------------------------------------------------

    // Same encoding for the read side and the write side
    typedef enum logic [1:0] {
        IDLE   = 2'd0,   // Ready for a new request
        RESP   = 2'd1,   // Holding an OKAY response
        REJECT = 2'd2    // Holding a SLVERR response
    } bus_state_t;

    // AXI response codes, only the two this slave returns
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axi_resp_t;

    // ------------------------------------------------------------
    // Decoded register select
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        MTIME_LO = 3'd0,
        MTIME_HI = 3'd1,
        CMP_LO   = 3'd2,
        CMP_HI   = 3'd3,
        MSIP     = 3'd4,
        NONE     = 3'd5   // Unmapped address
    } reg_sel_t;

endpackage

// File: common/clint_defs.svh
`ifndef CLINT_DEFS_SVH
`define CLINT_DEFS_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define CLINT_ADDR_W 32
`define CLINT_DATA_W 32
`define CLINT_ID_W   4

// ------------------------------------------------------------
// Register map
// ------------------------------------------------------------

// mtime words, low word first
`define CLINT_MTIME_LO 32'h0200_0000
`define CLINT_MTIME_HI 32'h0200_0004

// Compare register and software interrupt
`define CLINT_CMP_LO   32'h0200_0008
`define CLINT_CMP_HI   32'h0200_000C
`define CLINT_MSIP     32'h0200_0010

// Compare value out of reset, far away so no timer interrupt fires
`define CLINT_CMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif
